// File: logic/board_pkg.sv
package board_pkg;

  // Serial line timing
  localparam int clks_per_bit = 16;  // Fixed bit period in sysclk cycles

  // Console word memory
  localparam int mem_words  = 64;
  localparam int addr_width = 6;  // Enough for mem_words
  localparam int word_width = 16;  // ND-100 word size

  // LED bit positions, before the active low inversion
  localparam int led_err      = 0;  // Sticky input error
  localparam int led_wr       = 1;  // Last CR performed a write
  localparam int led_addr_lsb = 2;  // Low four bits of open address

endpackage

// File: logic/console_pkg.sv
package console_pkg;

  import board_pkg::*;

  // ASCII codes seen or produced by the console
  localparam logic [7:0] ch_slash = 8'h2F;  // Open word
  localparam logic [7:0] ch_cr    = 8'h0D;  // Deposit or plain newline
  localparam logic [7:0] ch_lf    = 8'h0A;
  localparam logic [7:0] ch_space = 8'h20;  // Ends an examine reply
  localparam logic [7:0] ch_quest = 8'h3F;  // Error reply
  localparam logic [7:0] ch_zero  = 8'h30;  // Octal digits follow it

  // Operations carried from decoder to formatter
  typedef enum logic [1:0] {
    op_examine = 2'd0,  // '/' after an address
    op_deposit = 2'd1,  // CR with digits on an open word
    op_newline = 2'd2,  // CR with nothing to write
    op_error   = 2'd3   // Anything unknown
  } op_t;

  // Decoder to memory
  typedef struct packed {
    op_t                   op;
    logic [addr_width-1:0] addr;  // Word to open or write
    logic [word_width-1:0] data;  // Typed value
  } cmd_t;

  // Memory to formatter
  typedef struct packed {
    op_t                   op;
    logic [word_width-1:0] data;   // Word read or written
    logic                  wrote;  // Set for a performed deposit
  } reply_t;

endpackage

// File: logic/uart_rx.sv
`timescale 1ns/10ps

module uart_rx import board_pkg::*; (
  input  logic       sysclk,      //! System clock
  input  logic       reset,       //! Synchronous, active high
  input  logic       rx,          //! Serial line, idle high
  output logic       byte_valid,  //! One cycle pulse per good frame
  output logic [7:0] byte_data    //! Received byte
);

  typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

  state_t                            state;
  logic   [1:0]                      rx_sync;  // Two flop synchroniser
  logic                              rx_s;
  logic   [$clog2(2*clks_per_bit)-1:0] cnt;      // Cycles since last sample point
  logic   [2:0]                      bit_idx;
  logic   [7:0]                      shift_q;

  assign rx_s      = rx_sync[1];
  assign byte_data = shift_q;

  always_ff @(posedge sysclk) begin
    if (reset) begin
      rx_sync <= 2'b11;  // Line idle
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      state      <= s_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        s_idle: begin
          cnt <= '0;
          if (!rx_s) begin
            state <= s_start;  // Falling edge of start bit
          end
        end
        s_start: begin
          if (cnt == clks_per_bit/2 - 1) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_s ? s_idle : s_data;  // Short glitch goes back to idle
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        s_data: begin
          if (cnt == clks_per_bit - 1) begin  // Middle of a data bit
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= s_stop;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          cnt <= cnt + 1'b1;
          if (cnt == clks_per_bit - 1 && !rx_s) begin
            state <= s_idle;  // Low stop bit, frame dropped
          end else if (cnt == clks_per_bit + clks_per_bit/2 - 3) begin
            byte_valid <= 1'b1;  // Just before end of stop bit
            state      <= s_idle;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge sysclk) begin
    if (state == s_data && cnt == clks_per_bit - 1) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

endmodule

// File: logic/octal_cmd_decoder.sv
`timescale 1ns/10ps

module octal_cmd_decoder import board_pkg::*, console_pkg::*; (
  input  logic       sysclk,      //! System clock
  input  logic       reset,       //! Synchronous, active high
  input  logic       byte_valid,  //! Byte from receiver
  input  logic [7:0] byte_data,
  output logic       cmd_valid,   //! Command waiting
  output cmd_t       cmd_data,
  input  logic       cmd_ready,
  output logic       err_flag     //! Sticky until next '/'
);

  logic [word_width-1:0] acc;        // Octal accumulator
  logic                  typed;      // Digits since last '/' or CR
  logic [addr_width-1:0] open_addr;
  logic                  is_open;
  logic                  take;
  logic                  is_digit;
  op_t                   cr_op;

  assign take     = byte_valid && !cmd_valid;  // Dropped while a command is held
  assign is_digit = (byte_data[7:3] == ch_zero[7:3]);  // '0' to '7'

  // CR writes only into an open word with fresh digits
  always_comb begin
    if (is_open && typed) begin
      cr_op = op_deposit;
    end else begin
      cr_op = op_newline;
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      acc       <= '0;
      typed     <= 1'b0;
      open_addr <= '0;
      is_open   <= 1'b0;
      cmd_valid <= 1'b0;
      err_flag  <= 1'b0;
    end else begin
      if (cmd_valid && cmd_ready) begin
        cmd_valid <= 1'b0;
      end
      if (take) begin
        if (is_digit) begin
          acc   <= {acc[word_width-4:0], byte_data[2:0]};  // Upper digits fall off
          typed <= 1'b1;
        end else if (byte_data == ch_slash) begin
          open_addr <= acc[addr_width-1:0];  // Address taken modulo memory size
          is_open   <= 1'b1;
          typed     <= 1'b0;
          acc       <= '0;
          err_flag  <= 1'b0;
          cmd_valid <= 1'b1;
        end else if (byte_data == ch_cr) begin
          is_open   <= 1'b0;  // CR closes the word
          typed     <= 1'b0;
          acc       <= '0;
          cmd_valid <= 1'b1;
        end else begin
          err_flag  <= 1'b1;
          cmd_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (take && !is_digit) begin
      if (byte_data == ch_slash) begin
        cmd_data <= '{op: op_examine, addr: acc[addr_width-1:0], data: acc};
      end else if (byte_data == ch_cr) begin
        cmd_data <= '{op: cr_op, addr: open_addr, data: acc};
      end else begin
        cmd_data <= '{op: op_error, addr: open_addr, data: acc};
      end
    end
  end

endmodule

// File: logic/pipe_buffer.sv
`timescale 1ns/10ps

module pipe_buffer #(
  parameter type payload_t = logic [7:0]  //! Item carried through the buffer
) (
  input  logic     sysclk,     //! System clock
  input  logic     reset,      //! Synchronous, active high
  input  logic     in_valid,
  output logic     in_ready,   //! Straight from a flop
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t main_q;      // Drives the output
  payload_t skid_q;      // Catches the item accepted during a stall
  logic     main_valid;
  logic     skid_valid;
  logic     main_free;

  assign in_ready  = !skid_valid;
  assign out_valid = main_valid;
  assign out_data  = main_q;
  assign main_free = out_ready || !main_valid;

  always_ff @(posedge sysclk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      main_valid <= skid_valid || in_valid;
      skid_valid <= 1'b0;  // Skid entry drains first
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge sysclk) begin
    if (main_free) begin
      main_q <= skid_valid ? skid_q : in_data;
    end else if (in_valid && in_ready) begin
      skid_q <= in_data;
    end
  end

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/10ps

module memory_stage import board_pkg::*, console_pkg::*; (
  input  logic                  sysclk,       //! System clock
  input  logic                  reset,        //! Synchronous, active high
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  cmd_t                  cmd_data,
  output logic                  reply_valid,
  input  logic                  reply_ready,
  output reply_t                reply_data,
  output logic                  wr_flag,      //! Last CR wrote a word
  output logic [addr_width-1:0] open_addr     //! Word opened by last examine
);

  logic [word_width-1:0] mem [mem_words];
  logic [mem_words-1:0]  written;  // Unwritten words read as zero
  logic                  accept;
  logic                  is_deposit;
  logic [word_width-1:0] rd_word;

  assign cmd_ready  = !reply_valid || reply_ready;  // Stall while reply is held
  assign accept     = cmd_valid && cmd_ready;
  assign is_deposit = (cmd_data.op == op_deposit);
  assign rd_word    = written[cmd_data.addr] ? mem[cmd_data.addr] : '0;

  always_ff @(posedge sysclk) begin
    if (accept && is_deposit) begin
      mem[cmd_data.addr] <= cmd_data.data;
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      reply_valid <= 1'b0;
      written     <= '0;
      wr_flag     <= 1'b0;
      open_addr   <= '0;
    end else begin
      if (accept) begin
        reply_valid <= 1'b1;
      end else if (reply_ready) begin
        reply_valid <= 1'b0;
      end
      if (accept) begin
        case (cmd_data.op)
          op_examine: open_addr <= cmd_data.addr;
          op_deposit: begin
            written[cmd_data.addr] <= 1'b1;
            wr_flag                <= 1'b1;
          end
          op_newline: wr_flag <= 1'b0;
          default: ;  // Errors leave state alone
        endcase
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (accept) begin
      reply_data.op    <= cmd_data.op;
      reply_data.wrote <= is_deposit;
      case (cmd_data.op)
        op_examine: reply_data.data <= rd_word;
        op_deposit: reply_data.data <= cmd_data.data;  // Echo of the written value
        default:    reply_data.data <= '0;
      endcase
    end
  end

endmodule

// File: logic/octal_reply_formatter.sv
`timescale 1ns/10ps

module octal_reply_formatter import board_pkg::*, console_pkg::*; (
  input  logic       sysclk,       //! System clock
  input  logic       reset,        //! Synchronous, active high
  input  logic       reply_valid,
  output logic       reply_ready,  //! Free between replies
  input  reply_t     reply_data,
  output logic       tx_valid,
  output logic [7:0] tx_data,      //! ASCII byte for transmitter
  input  logic       tx_ready
);

  op_t                   op_q;
  logic [word_width+1:0] digits_q;  // Word padded to six octal digits
  logic [2:0]            idx;       // Byte position within reply
  logic                  last;

  assign reply_ready = !tx_valid;

  always_comb begin
    case (op_q)
      op_examine: begin
        if (idx == 3'd6) begin
          tx_data = ch_space;
        end else begin
          tx_data = ch_zero | {5'd0, digits_q[word_width+1 -: 3]};  // Top digit first
        end
        last = (idx == 3'd6);
      end
      op_deposit, op_newline: begin
        tx_data = (idx == 3'd0) ? ch_cr : ch_lf;
        last    = (idx == 3'd1);
      end
      default: begin
        tx_data = ch_quest;  // Single byte
        last    = 1'b1;
      end
    endcase
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      tx_valid <= 1'b0;
      idx      <= '0;
    end else if (!tx_valid) begin
      if (reply_valid) begin
        tx_valid <= 1'b1;
        idx      <= '0;
      end
    end else if (tx_ready) begin
      if (last) begin
        tx_valid <= 1'b0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (!tx_valid && reply_valid) begin
      op_q     <= reply_data.op;
      digits_q <= {2'b00, reply_data.data};  // First digit holds a single bit
    end else if (tx_valid && tx_ready) begin
      digits_q <= {digits_q[word_width-2:0], 3'b000};
    end
  end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/10ps

module uart_tx import board_pkg::*; (
  input  logic       sysclk,    //! System clock
  input  logic       reset,     //! Synchronous, active high
  input  logic       tx_valid,
  output logic       tx_ready,  //! High only while idle
  input  logic [7:0] tx_data,
  output logic       tx         //! Serial line, 8N1
);

  logic                            busy;
  logic [9:0]                      frame_q;  // Stop, data, start
  logic [$clog2(clks_per_bit)-1:0] cnt;
  logic [3:0]                      bit_idx;

  assign tx_ready = !busy;
  assign tx       = frame_q[0];  // Flop output, no glitches

  always_ff @(posedge sysclk) begin
    if (reset) begin
      busy    <= 1'b0;
      frame_q <= '1;  // Idle high
      cnt     <= '0;
      bit_idx <= '0;
    end else if (!busy) begin
      if (tx_valid) begin
        frame_q <= {1'b1, tx_data, 1'b0};
        busy    <= 1'b1;
        cnt     <= '0;
        bit_idx <= '0;
      end
    end else if (cnt == clks_per_bit - 1) begin
      // End of a bit period
      cnt     <= '0;
      frame_q <= {1'b1, frame_q[9:1]};  // Refill with idle level
      bit_idx <= bit_idx + 1'b1;
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;  // Stop bit done
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: logic/nd120_top.sv
`timescale 1ns/10ps

module nd120_top import board_pkg::*, console_pkg::*; (
  input  logic       sysclk,   //! System clock
  input  logic       reset,    //! Synchronous, active high
  input  logic       uart_rx,  //! Console receive pin
  output logic       uart_tx,  //! Console transmit pin
  output logic [5:0] led       //! Active low board LEDs
);

  logic                  byte_valid;
  logic [7:0]            byte_data;
  logic                  cmd_valid;
  logic                  cmd_ready;
  cmd_t                  cmd_data;
  logic                  mem_cmd_valid;  // Buffered command
  logic                  mem_cmd_ready;
  cmd_t                  mem_cmd_data;
  logic                  reply_valid;
  logic                  reply_ready;
  reply_t                reply_data;
  logic                  fmt_valid;      // Buffered reply
  logic                  fmt_ready;
  reply_t                fmt_data;
  logic                  tx_valid;
  logic                  tx_ready;
  logic [7:0]            tx_data;
  logic                  err_flag;
  logic                  wr_flag;
  logic [addr_width-1:0] open_addr;

  // Nano LEDs light on a low level
  assign led[led_err]           = ~err_flag;
  assign led[led_wr]            = ~wr_flag;
  assign led[led_addr_lsb +: 4] = ~open_addr[3:0];

  uart_rx i_uart_rx (
    .sysclk(sysclk), .reset(reset), .rx(uart_rx),
    .byte_valid(byte_valid), .byte_data(byte_data)
  );

  octal_cmd_decoder i_decoder (
    .sysclk(sysclk), .reset(reset), .byte_valid(byte_valid), .byte_data(byte_data),
    .cmd_valid(cmd_valid), .cmd_data(cmd_data), .cmd_ready(cmd_ready), .err_flag(err_flag)
  );

  pipe_buffer #(.payload_t(cmd_t)) i_cmd_buf (
    .sysclk(sysclk), .reset(reset),
    .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_data),
    .out_valid(mem_cmd_valid), .out_ready(mem_cmd_ready), .out_data(mem_cmd_data)
  );

  memory_stage i_memory (
    .sysclk(sysclk), .reset(reset),
    .cmd_valid(mem_cmd_valid), .cmd_ready(mem_cmd_ready), .cmd_data(mem_cmd_data),
    .reply_valid(reply_valid), .reply_ready(reply_ready), .reply_data(reply_data),
    .wr_flag(wr_flag), .open_addr(open_addr)
  );

  pipe_buffer #(.payload_t(reply_t)) i_reply_buf (
    .sysclk(sysclk), .reset(reset),
    .in_valid(reply_valid), .in_ready(reply_ready), .in_data(reply_data),
    .out_valid(fmt_valid), .out_ready(fmt_ready), .out_data(fmt_data)
  );

  octal_reply_formatter i_formatter (
    .sysclk(sysclk), .reset(reset),
    .reply_valid(fmt_valid), .reply_ready(fmt_ready), .reply_data(fmt_data),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready)
  );

  uart_tx i_uart_tx (
    .sysclk(sysclk), .reset(reset), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .tx_data(tx_data), .tx(uart_tx)
  );

endmodule

// File: verif/nd120_top_sva.sv
`timescale 1ns/10ps

module nd120_top_sva import console_pkg::*; (
  input logic   sysclk,
  input logic   reset,
  input logic   uart_tx,
  input logic   cmd_valid,    // Decoder to command buffer
  input logic   cmd_ready,
  input cmd_t   cmd_data,
  input logic   reply_valid,  // Memory stage to reply buffer
  input logic   reply_ready,
  input reply_t reply_data
);

  int fail_count = 0;  // Failed assertions so far

  // Line idles high while held in reset
  a_tx_idle_in_reset: assert property (@(posedge sysclk) reset |=> uart_tx)
    else begin
      $error("uart_tx left idle level during reset");
      fail_count++;
    end

  a_cmd_hold: assert property (@(posedge sysclk) disable iff (reset)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
    else begin
      $error("Command dropped or changed before cmd_ready");
      fail_count++;
    end

  // Stalled reply must wait unchanged
  a_reply_hold: assert property (@(posedge sysclk) disable iff (reset)
    reply_valid && !reply_ready |=> reply_valid && $stable(reply_data))
    else begin
      $error("Reply dropped or changed before reply_ready");
      fail_count++;
    end

endmodule

// File: verif/console_checker.sv
`timescale 1ns/10ps

module console_checker import board_pkg::*; (
  input  logic       sysclk,
  input  logic       reset,
  input  logic       uart_tx,         // Serial output of the DUT
  input  logic [5:0] led,             // Pin level, active low
  output logic       reply_done,      // Whole expected reply seen
  output int         mismatch_count,
  output int         protocol_count   // Framing faults and stray bytes
);

  logic [7:0] exp_q[$];   // Bytes still owed by the DUT
  logic [5:0] led_exp;
  string      test_name;

  task automatic begin_test(input string name, input logic [5:0] led_after);
    test_name  = name;
    led_exp    = led_after;
    exp_q.delete();
    reply_done <= 1'b0;
  endtask

  task automatic push_expected(input logic [7:0] b);
    exp_q.push_back(b);
  endtask

  task automatic check_byte(input logic [7:0] b);
    logic [7:0] want;
    if (exp_q.size() == 0) begin
      $display("Unexpected byte 8'h%02h on uart_tx in test %s", b, test_name);
      protocol_count++;
    end else begin
      want = exp_q.pop_front();
      if (b !== want) begin
        $display("Mismatch in test %s: expected 8'h%02h, actual 8'h%02h", test_name, want, b);
        mismatch_count++;
      end
      if (exp_q.size() == 0) begin
        // LEDs settle long before the last stop bit
        if (led !== led_exp) begin
          $display("Mismatch in test %s led: expected 6'h%02h, actual 6'h%02h",
                   test_name, led_exp, led);
          mismatch_count++;
        end
        reply_done <= 1'b1;
      end
    end
  endtask

  // 8N1 receiver, samples near mid bit
  initial begin
    logic [7:0] b;
    mismatch_count = 0;
    protocol_count = 0;
    reply_done     = 1'b0;
    forever begin
      @(posedge sysclk);
      if (!reset && uart_tx === 1'b0) begin
        repeat (clks_per_bit/2) @(posedge sysclk);  // Middle of start bit
        if (uart_tx !== 1'b0) begin
          $display("Start bit on uart_tx shorter than half a bit in test %s", test_name);
          protocol_count++;
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(posedge sysclk);
            b[i] = uart_tx;  // LSB first
          end
          repeat (clks_per_bit) @(posedge sysclk);
          if (uart_tx !== 1'b1) begin
            $display("Framing error on uart_tx, stop bit low in test %s", test_name);
            protocol_count++;
          end else begin
            check_byte(b);
          end
        end
      end
    end
  end

endmodule

// File: verif/tb_nd120_top.sv
`timescale 1ns/10ps

module tb_nd120_top import board_pkg::*;;

  logic       sysclk;
  logic       reset;
  logic       uart_rx;
  logic       uart_tx;
  logic [5:0] led;
  logic       reply_done;
  int         mismatch_count;
  int         protocol_count;
  int         run_errors;  // Timeout or missing golden data

  // Golden data per test line
  string      names[$];
  int         stim_cnt[$];
  int         exp_cnt[$];
  logic [7:0] stim_q[$];   // All stimulus bytes back to back
  logic [7:0] exp_q[$];
  logic [5:0] led_q[$];

  nd120_top i_dut (
    .sysclk(sysclk), .reset(reset), .uart_rx(uart_rx), .uart_tx(uart_tx), .led(led)
  );

  console_checker i_checker (
    .sysclk(sysclk), .reset(reset), .uart_tx(uart_tx), .led(led),
    .reply_done(reply_done), .mismatch_count(mismatch_count),
    .protocol_count(protocol_count)
  );

  bind nd120_top nd120_top_sva i_sva (
    .sysclk(sysclk), .reset(reset), .uart_tx(uart_tx),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data),
    .reply_valid(reply_valid), .reply_ready(reply_ready), .reply_data(reply_data)
  );

  always #10 sysclk = ~sysclk;  // 20 ns period

  task automatic read_golden();
    int    fd;
    int    code;
    int    n;
    int    v;
    string tok;
    string rest;
    fd = $fopen("verif/console_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verif/console_golden.txt");
      run_errors++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok[0] == 8'h23) begin
        code = $fgets(rest, fd);  // Comment line
      end else begin
        names.push_back(tok);
        code = $fscanf(fd, "%d", n);
        stim_cnt.push_back(n);
        for (int i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", v);
          stim_q.push_back(v[7:0]);
        end
        code = $fscanf(fd, "%d", n);
        exp_cnt.push_back(n);
        for (int i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", v);
          exp_q.push_back(v[7:0]);
        end
        code = $fscanf(fd, "%h", v);
        led_q.push_back(v[5:0]);
      end
    end
    $fclose(fd);
  endtask

  // Random idle gap then one 8N1 frame LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    repeat ($urandom_range(40, 0)) @(posedge sysclk);
    for (int i = 0; i < 10; i++) begin
      @(posedge sysclk);
      uart_rx <= frame[i];
      repeat (clks_per_bit - 1) @(posedge sysclk);
    end
  endtask

  task automatic wait_reply();
    @(posedge sysclk);
    while (!reply_done) @(posedge sysclk);
  endtask

  task automatic run_tests();
    int s_idx;
    int e_idx;
    s_idx = 0;
    e_idx = 0;
    for (int t = 0; t < names.size(); t++) begin
      i_checker.begin_test(names[t], led_q[t]);
      for (int i = 0; i < exp_cnt[t]; i++) begin
        i_checker.push_expected(exp_q[e_idx + i]);
      end
      e_idx += exp_cnt[t];
      for (int i = 0; i < stim_cnt[t]; i++) begin
        send_byte(stim_q[s_idx + i]);
        if (stim_q[s_idx + i][7:3] != 5'b00110) begin
          wait_reply();  // Anything but '0' to '7' is a command
        end
      end
      s_idx += stim_cnt[t];
    end
  endtask

  task automatic finish_run();
    int sva_errors;
    sva_errors = i_dut.i_sva.fail_count;
    $display("Errors: %0d mismatch, %0d protocol, %0d assertion, %0d run",
             mismatch_count, protocol_count, sva_errors, run_errors);
    if (mismatch_count + protocol_count + sva_errors + run_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    longint total;
    longint limit_ns;
    void'($urandom(13));
    sysclk     = 1'b0;
    reset      = 1'b1;
    uart_rx    = 1'b1;  // Line idle
    run_errors = 0;
    total      = 0;
    read_golden();
    if (names.size() == 0) begin
      $display("No tests found in the golden file");
      run_errors++;
    end
    for (int t = 0; t < names.size(); t++) begin
      total += stim_cnt[t] + exp_cnt[t];
    end
    limit_ns = total * 10 * clks_per_bit * 20 * 3 + 10000;
    fork
      begin
        #(limit_ns);
        $display("Timeout after %0d ns, DUT stopped replying", limit_ns);
        run_errors++;
        finish_run();
      end
    join_none
    repeat (8) @(posedge sysclk);
    reset <= 1'b0;
    run_tests();
    repeat (4 * 10 * clks_per_bit) @(posedge sysclk);  // Catch stray bytes
    finish_run();
  end

endmodule

// File: verif/console_golden.txt
# name  stim_count stim_bytes  reply_count reply_bytes  led_after (bytes and led in hex)
# led_after is the pin level once the reply is out, LEDs are active low
fresh_exam   2 35 2f                        7 30 30 30 30 30 30 20  2b
dep_open     2 35 2f                        7 30 30 30 30 30 30 20  2b
dep_write    5 31 32 33 34 0d               2 0d 0a                 29
dep_read     2 35 2f                        7 30 30 31 32 33 34 20  29
wrap_write   9 31 32 31 37 37 37 37 37 0d   2 0d 0a                 29
wrap_read    4 31 30 35 2f                  7 31 37 37 37 37 37 20  29
cr_open      2 35 2f                        7 31 37 37 37 37 37 20  29
cr_empty     1 0d                           2 0d 0a                 2b
cr_check     2 35 2f                        7 31 37 37 37 37 37 20  2b
err_char     1 58                           1 3f                    2a
err_clear    2 35 2f                        7 31 37 37 37 37 37 20  2b

// File: filelist.f
logic/board_pkg.sv
logic/console_pkg.sv
logic/uart_rx.sv
logic/octal_cmd_decoder.sv
logic/pipe_buffer.sv
logic/memory_stage.sv
logic/octal_reply_formatter.sv
logic/uart_tx.sv
logic/nd120_top.sv
verif/nd120_top_sva.sv
verif/console_checker.sv
verif/tb_nd120_top.sv
